// ==== src/mult_pkg.sv ====
// shared constants for the mailbox multiplier
// command and result word layouts assume OPND_W of 4 and WORD_W of 32
package mult_pkg;

        // ==============================
        // widths
        // ==============================
        localparam int OPND_W = 4;              // operand width
        localparam int PROD_W = 2 * OPND_W;     // product width, 8
        localparam int WORD_W = 32;             // ram word
        localparam int ADDR_W = 4;              // 16 words

        // ==============================
        // mailbox layout
        // ==============================
        localparam logic [ADDR_W-1:0] CMD_ADDR = ADDR_W'(0); // command word
        localparam logic [ADDR_W-1:0] RES_ADDR = ADDR_W'(1); // result word
        localparam int GO_BIT   = 31;           // cmd: request a multiply
        localparam int DONE_BIT = 31;           // res: product is ready
        localparam int MULT_LAT = 5;            // start strobe to done pulse

        // multiplier fsm, add/shift tell which op the current iteration does
        typedef enum logic [3:0] {
                MS_IDLE = 4'd0,
                MS_ADD,
                MS_SHIFT,
                MS_DONE
        } mult_state_t;

        typedef enum logic [3:0] {
                CS_POLL = 4'd0,                 // present CMD_ADDR
                CS_CHECK,                       // look at go bit
                CS_START,                       // strobe the multiplier
                CS_WAIT,                        // wait for done
                CS_WRITE_RES,
                CS_CLEAR_GO
        } ctrl_state_t;

        // active low, g in bit 6 down to a in bit 0
        localparam logic [6:0] SEG_FONT [0:15] = '{
                7'h40, 7'h79, 7'h24, 7'h30,     // 0 1 2 3
                7'h19, 7'h12, 7'h02, 7'h78,     // 4 5 6 7
                7'h00, 7'h10, 7'h08, 7'h03,     // 8 9 A b
                7'h46, 7'h21, 7'h06, 7'h0E      // C d E F
        };

endpackage

// ==== src/test_ram.sv ====
// dual-port test ram, contents not reset
// host port reads back its own write on the same edge; controller port reads old data
// host wins when both ports write one word together
`timescale 1ns/1ps

module test_ram (
        input  logic                        clk_i,
        // host side
        input  logic                        host_we_i,
        input  logic [mult_pkg::ADDR_W-1:0] host_addr_i,
        input  logic [mult_pkg::WORD_W-1:0] host_wdata_i,
        output logic [mult_pkg::WORD_W-1:0] host_rdata_o,
        // controller side
        input  logic                        ctl_we_i,
        input  logic [mult_pkg::ADDR_W-1:0] ctl_addr_i,
        input  logic [mult_pkg::WORD_W-1:0] ctl_wdata_i,
        output logic [mult_pkg::WORD_W-1:0] ctl_rdata_o
);
        import mult_pkg::*;

        logic [WORD_W-1:0] mem [0:(1<<ADDR_W)-1];

        always_ff @(posedge clk_i) begin
                // controller write first so the host write lands last
                if (ctl_we_i)
                        mem[ctl_addr_i] <= ctl_wdata_i;
                if (host_we_i)
                        mem[host_addr_i] <= host_wdata_i;

                // host read, own write shows through
                if (host_we_i)
                        host_rdata_o <= host_wdata_i;
                else
                        host_rdata_o <= mem[host_addr_i];

                ctl_rdata_o <= mem[ctl_addr_i]; // old contents
        end

endmodule

// ==== src/shift_add_multiplier.sv ====
// unsigned shift-add multiplier, one iteration per cycle
// done pulses MULT_LAT cycles after start; start outside MS_IDLE is ignored
`timescale 1ns/1ps

module shift_add_multiplier (
        input  logic                        clk_i,
        input  logic                        rst_n_i,
        input  logic                        start_i,
        input  logic [mult_pkg::OPND_W-1:0] op_a_i,
        input  logic [mult_pkg::OPND_W-1:0] op_b_i,
        output logic                        done_o,
        output logic [mult_pkg::PROD_W-1:0] product_o,
        output mult_pkg::mult_state_t       state_o
);
        import mult_pkg::*;

        localparam int CNT_W = $clog2(OPND_W);

        mult_state_t        state_q;
        logic [CNT_W-1:0]   iter_q;             // iteration index
        logic [PROD_W-1:0]  acc_q;              // running product
        logic [PROD_W-1:0]  mcand_q;            // multiplicand, shifts left
        logic [OPND_W-1:0]  mplier_q;           // multiplier, shifts right

        wire go = start_i && (state_q == MS_IDLE);
        wire busy = (state_q == MS_ADD) || (state_q == MS_SHIFT);

        // ==============================
        // control
        // ==============================
        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        state_q <= MS_IDLE;
                        iter_q  <= '0;
                        acc_q   <= '0;
                end else if (go) begin
                        iter_q  <= '0;
                        acc_q   <= '0;
                        state_q <= op_b_i[0] ? MS_ADD : MS_SHIFT;      // first bit decides
                end else if (busy) begin
                        if (state_q == MS_ADD)
                                acc_q <= acc_q + mcand_q;
                        iter_q <= iter_q + 1'b1;
                        if (iter_q == CNT_W'(OPND_W-1))
                                state_q <= MS_DONE;                    // last bit done
                        else
                                state_q <= mplier_q[1] ? MS_ADD : MS_SHIFT;
                end else if (state_q == MS_DONE) begin
                        state_q <= MS_IDLE;
                end
        end

        // operand shifters, loaded on start
        always_ff @(posedge clk_i) begin
                if (go) begin
                        mcand_q  <= PROD_W'(op_a_i);
                        mplier_q <= op_b_i;
                end else if (busy) begin
                        mcand_q  <= mcand_q << 1;
                        mplier_q <= mplier_q >> 1;
                end
        end

        assign done_o    = (state_q == MS_DONE);
        assign product_o = acc_q;               // valid from done to next start
        assign state_o   = state_q;

endmodule

// ==== src/mailbox_controller.sv ====
// polls the command word, runs one multiply at a time, posts the result
// the host must not rewrite CMD_ADDR until DONE_BIT shows in the result word
`timescale 1ns/1ps

module mailbox_controller (
        input  logic                        clk_i,
        input  logic                        rst_n_i,
        // ram controller port
        output logic [mult_pkg::ADDR_W-1:0] ram_addr_o,
        output logic                        ram_we_o,
        output logic [mult_pkg::WORD_W-1:0] ram_wdata_o,
        input  logic [mult_pkg::WORD_W-1:0] ram_rdata_i,
        // multiplier link
        output logic                        mult_start_o,
        output logic [mult_pkg::OPND_W-1:0] op_a_o,
        output logic [mult_pkg::OPND_W-1:0] op_b_o,
        input  logic                        mult_done_i,
        input  logic [mult_pkg::PROD_W-1:0] product_i,
        output mult_pkg::ctrl_state_t       state_o
);
        import mult_pkg::*;

        ctrl_state_t        state_q;
        logic [OPND_W-1:0]  op_a_q;
        logic [OPND_W-1:0]  op_b_q;

        // ==============================
        // state register
        // ==============================
        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        state_q <= CS_POLL;
                        op_a_q  <= '0;          // display shows 0 out of reset
                        op_b_q  <= '0;
                end else begin
                        case (state_q)
                        CS_POLL:  state_q <= CS_CHECK;  // read data is back next cycle
                        CS_CHECK: begin
                                if (ram_rdata_i[GO_BIT]) begin
                                        op_a_q  <= ram_rdata_i[OPND_W-1:0];
                                        op_b_q  <= ram_rdata_i[2*OPND_W-1:OPND_W];
                                        state_q <= CS_START;
                                end else begin
                                        state_q <= CS_POLL;     // keep polling
                                end
                        end
                        CS_START: state_q <= CS_WAIT;
                        CS_WAIT: begin
                                if (mult_done_i)
                                        state_q <= CS_WRITE_RES;
                        end
                        CS_WRITE_RES: state_q <= CS_CLEAR_GO;
                        CS_CLEAR_GO:  state_q <= CS_POLL;
                        default:      state_q <= CS_POLL;
                        endcase
                end
        end

        // ==============================
        // ram and multiplier outputs
        // ==============================
        always_comb begin
                ram_addr_o  = CMD_ADDR;         // idle address is the command word
                ram_we_o    = 1'b0;
                ram_wdata_o = '0;
                case (state_q)
                CS_WRITE_RES: begin
                        ram_addr_o                = RES_ADDR;
                        ram_we_o                  = 1'b1;
                        ram_wdata_o[DONE_BIT]     = 1'b1;
                        ram_wdata_o[PROD_W-1:0]   = product_i;  // held since done
                end
                CS_CLEAR_GO: begin
                        // same operands, go bit left at 0
                        ram_we_o                         = 1'b1;
                        ram_wdata_o[OPND_W-1:0]          = op_a_q;
                        ram_wdata_o[2*OPND_W-1:OPND_W]   = op_b_q;
                end
                default: ;
                endcase
        end

        assign mult_start_o = (state_q == CS_START);    // one cycle strobe
        assign op_a_o       = op_a_q;
        assign op_b_o       = op_b_q;
        assign state_o      = state_q;

endmodule

// ==== src/hex_display.sv ====
// six seven-segment digits, active low, no decimal points
// inputs are sampled once per clock, digits lag by one cycle
`timescale 1ns/1ps

module hex_display (
        input  logic                        clk_i,
        input  logic                        rst_n_i,
        input  logic [mult_pkg::OPND_W-1:0] op_a_i,
        input  logic [mult_pkg::OPND_W-1:0] op_b_i,
        input  mult_pkg::mult_state_t       mult_state_i,
        input  mult_pkg::ctrl_state_t       ctrl_state_i,
        input  logic [mult_pkg::PROD_W-1:0] product_i,
        output logic [6:0]                  hex0_o,
        output logic [6:0]                  hex1_o,
        output logic [6:0]                  hex2_o,
        output logic [6:0]                  hex3_o,
        output logic [6:0]                  hex4_o,
        output logic [6:0]                  hex5_o
);
        import mult_pkg::*;

        logic [OPND_W-1:0]  a_q;
        logic [OPND_W-1:0]  b_q;
        mult_state_t        ms_q;
        ctrl_state_t        cs_q;
        logic [PROD_W-1:0]  prod_q;

        // ==============================
        // display registers
        // ==============================
        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        a_q    <= '0;           // every digit reads 0
                        b_q    <= '0;
                        ms_q   <= MS_IDLE;
                        cs_q   <= CS_POLL;
                        prod_q <= '0;
                end else begin
                        a_q    <= op_a_i;
                        b_q    <= op_b_i;
                        ms_q   <= mult_state_i;
                        cs_q   <= ctrl_state_i;
                        prod_q <= product_i;
                end
        end

        // font lookup
        assign hex0_o = SEG_FONT[a_q];
        assign hex1_o = SEG_FONT[b_q];
        assign hex2_o = SEG_FONT[ms_q];                 // enums are one nibble
        assign hex3_o = SEG_FONT[cs_q];
        assign hex4_o = SEG_FONT[prod_q[3:0]];          // low nibble
        assign hex5_o = SEG_FONT[prod_q[7:4]];

endmodule

// ==== src/mult_soc_top.sv ====
// fabric top: ram, mailbox controller, multiplier and displays
// host port stands in for the processor side, one command in flight
`timescale 1ns/1ps

module mult_soc_top (
        input  logic                        clk_i,
        input  logic                        rst_n_i,
        // host port
        input  logic                        host_we_i,
        input  logic [mult_pkg::ADDR_W-1:0] host_addr_i,
        input  logic [mult_pkg::WORD_W-1:0] host_wdata_i,
        output logic [mult_pkg::WORD_W-1:0] host_rdata_o,
        // seven-segment digits
        output logic [6:0]                  hex0_o,
        output logic [6:0]                  hex1_o,
        output logic [6:0]                  hex2_o,
        output logic [6:0]                  hex3_o,
        output logic [6:0]                  hex4_o,
        output logic [6:0]                  hex5_o
);
        import mult_pkg::*;

        // ==============================
        // internal wiring
        // ==============================
        logic [ADDR_W-1:0]  ram_addr;
        logic               ram_we;
        logic [WORD_W-1:0]  ram_wdata;
        logic [WORD_W-1:0]  ram_rdata;
        logic               mult_start;
        logic               mult_done;
        logic [OPND_W-1:0]  op_a;
        logic [OPND_W-1:0]  op_b;
        logic [PROD_W-1:0]  product;
        mult_state_t        mult_state;
        ctrl_state_t        ctrl_state;

        test_ram u_ram (
                .clk_i        (clk_i),
                .host_we_i    (host_we_i),
                .host_addr_i  (host_addr_i),
                .host_wdata_i (host_wdata_i),
                .host_rdata_o (host_rdata_o),
                .ctl_we_i     (ram_we),         // controller side
                .ctl_addr_i   (ram_addr),
                .ctl_wdata_i  (ram_wdata),
                .ctl_rdata_o  (ram_rdata)
        );

        mailbox_controller u_ctrl (
                .clk_i        (clk_i),
                .rst_n_i      (rst_n_i),
                .ram_addr_o   (ram_addr),
                .ram_we_o     (ram_we),
                .ram_wdata_o  (ram_wdata),
                .ram_rdata_i  (ram_rdata),
                .mult_start_o (mult_start),
                .op_a_o       (op_a),
                .op_b_o       (op_b),
                .mult_done_i  (mult_done),
                .product_i    (product),
                .state_o      (ctrl_state)
        );

        shift_add_multiplier u_mult (
                .clk_i     (clk_i),
                .rst_n_i   (rst_n_i),
                .start_i   (mult_start),
                .op_a_i    (op_a),
                .op_b_i    (op_b),
                .done_o    (mult_done),
                .product_o (product),
                .state_o   (mult_state)
        );

        hex_display u_disp (
                .clk_i        (clk_i),
                .rst_n_i      (rst_n_i),
                .op_a_i       (op_a),
                .op_b_i       (op_b),
                .mult_state_i (mult_state),     // hex2
                .ctrl_state_i (ctrl_state),     // hex3
                .product_i    (product),
                .hex0_o       (hex0_o),
                .hex1_o       (hex1_o),
                .hex2_o       (hex2_o),
                .hex3_o       (hex3_o),
                .hex4_o       (hex4_o),
                .hex5_o       (hex5_o)
        );

endmodule

// ==== verification/clk_gen.sv ====
// 10 ns clock, reset low until just after the 4th rising edge
`timescale 1ns/1ps

module clk_gen (
        output logic clk_o,
        output logic rst_n_o
);
        initial begin
                clk_o = 1'b0;
                forever #5 clk_o = ~clk_o;      // 100 MHz
        end

        initial begin
                rst_n_o = 1'b0;
                repeat (4) @(posedge clk_o);
                #1 rst_n_o = 1'b1;              // released between edges
        end

endmodule

// ==== verification/mult_props.sv ====
// handshake and display checks, bound into mult_soc_top
// all properties are disabled while reset is low
`timescale 1ns/1ps

module mult_props (
        input logic       clk_i,
        input logic       rst_n_i,
        input logic       mult_start_i,
        input logic       mult_done_i,
        input logic [6:0] hex0_i,
        input logic [6:0] hex1_i,
        input logic [6:0] hex2_i,
        input logic [6:0] hex3_i,
        input logic [6:0] hex4_i,
        input logic [6:0] hex5_i
);
        import mult_pkg::*;

        int fail_cnt = 0;       // read back by tb_top at the end

        // done is a single-cycle pulse
        done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                mult_done_i |=> !mult_done_i)
                else begin
                        fail_cnt++;
                        $error("mult_done stayed high for more than one cycle");
                end

        // done exactly MULT_LAT cycles after start, and never otherwise
        done_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                mult_done_i == $past(mult_start_i, MULT_LAT))
                else begin
                        fail_cnt++;
                        $error("mult_done not %0d cycles after mult_start", MULT_LAT);
                end

        digits_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                !$isunknown({hex5_i, hex4_i, hex3_i, hex2_i, hex1_i, hex0_i}))
                else begin
                        fail_cnt++;
                        $error("a hex digit output is unknown");
                end

endmodule

bind mult_soc_top mult_props u_props (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .mult_start_i (mult_start),
        .mult_done_i  (mult_done),
        .hex0_i       (hex0_o),
        .hex1_i       (hex1_o),
        .hex2_i       (hex2_o),
        .hex3_i       (hex3_o),
        .hex4_i       (hex4_o),
        .hex5_i       (hex5_o)
);

// ==== verification/tb_top.sv ====
// drives mult_soc_top through its host port, vectors from verification/mult_tests.txt
// run from the project root; every wait gives up after 100 cycles
`timescale 1ns/1ps

module tb_top;
        import mult_pkg::*;

        localparam int TIMEOUT   = 100;         // cycles per wait
        localparam int MAX_TESTS = 40;          // 3 words each, fits in vec

        logic               clk;
        logic               rst_n;
        logic               host_we;
        logic [ADDR_W-1:0]  host_addr;
        logic [WORD_W-1:0]  host_wdata;
        logic [WORD_W-1:0]  host_rdata;
        logic [6:0]         hex0;
        logic [6:0]         hex1;
        logic [6:0]         hex2;
        logic [6:0]         hex3;
        logic [6:0]         hex4;
        logic [6:0]         hex5;
        logic [7:0]         vec [0:127];        // a, b, product per test
        int                 errors;
        int                 tests_run;
        int                 tests_failed;
        bit                 hung;               // some wait timed out

        clk_gen u_clk (
                .clk_o   (clk),
                .rst_n_o (rst_n)
        );

        mult_soc_top UUT (
                .clk_i        (clk),
                .rst_n_i      (rst_n),
                .host_we_i    (host_we),
                .host_addr_i  (host_addr),
                .host_wdata_i (host_wdata),
                .host_rdata_o (host_rdata),
                .hex0_o       (hex0),
                .hex1_o       (hex1),
                .hex2_o       (hex2),
                .hex3_o       (hex3),
                .hex4_o       (hex4),
                .hex5_o       (hex5)
        );

        // ==============================
        // expected words
        // ==============================
        function automatic logic [WORD_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
                return {4{~addr, addr}};        // every address bit shows up
        endfunction

        function automatic logic [WORD_W-1:0] cmd_word(input logic [7:0] a, input logic [7:0] b);
                logic [WORD_W-1:0] w;
                w = '0;
                w[GO_BIT] = 1'b1;
                w[7:0] = {b[3:0], a[3:0]};      // b high nibble, a low
                return w;
        endfunction

        function automatic logic [WORD_W-1:0] result_word(input logic [7:0] prod);
                logic [WORD_W-1:0] w;
                w = '0;
                w[DONE_BIT] = 1'b1;
                w[PROD_W-1:0] = prod;
                return w;
        endfunction

        // ==============================
        // host port, all tasks start and end on a falling edge
        // ==============================
        task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
                host_we    = 1'b1;
                host_addr  = addr;
                host_wdata = data;
                @(negedge clk);                 // written on the rising edge between
                host_we    = 1'b0;
        endtask

        task automatic read_word(input logic [ADDR_W-1:0] addr, output logic [WORD_W-1:0] data);
                host_we   = 1'b0;
                host_addr = addr;
                @(negedge clk);
                data = host_rdata;              // one cycle of latency
        endtask

        task automatic report_mismatch(input string name, input logic [WORD_W-1:0] exp,
                                       input logic [WORD_W-1:0] got);
                $display("mismatch at %0t ns: %s expected %h got %h", $time, name, exp, got);
                errors++;
        endtask

        task automatic check_digit(input string name, input logic [6:0] got, input logic [3:0] value);
                if (got !== SEG_FONT[value])
                        report_mismatch(name, WORD_W'(SEG_FONT[value]), WORD_W'(got));
        endtask

        task automatic finish_test(input string name, input int errs_before);
                tests_run++;
                if (errors != errs_before || hung) begin
                        tests_failed++;
                        $display("test %0d %s: failed", tests_run, name);
                end else begin
                        $display("test %0d %s: ok", tests_run, name);
                end
        endtask

        // ==============================
        // waits
        // ==============================
        task automatic wait_reset_release();
                int cycles;
                cycles = 0;
                while (rst_n !== 1'b1 && cycles < TIMEOUT) begin
                        @(negedge clk);
                        cycles++;
                end
                if (rst_n !== 1'b1) begin
                        $display("timeout: reset was never released");
                        hung = 1'b1;
                end
        endtask

        task automatic wait_done(output logic [WORD_W-1:0] res);
                int cycles;
                cycles = 0;
                res = '0;
                while (res[DONE_BIT] !== 1'b1 && cycles < TIMEOUT) begin
                        read_word(RES_ADDR, res);       // poll the result word
                        cycles++;
                end
                if (res[DONE_BIT] !== 1'b1) begin
                        $display("timeout: result word never showed the done bit");
                        hung = 1'b1;
                end
        endtask

        task automatic wait_display_idle();
                int cycles;
                cycles = 0;
                // controller alternates poll and check, so catch a poll cycle
                while ((hex2 !== SEG_FONT[MS_IDLE] || hex3 !== SEG_FONT[CS_POLL])
                       && cycles < TIMEOUT) begin
                        @(negedge clk);
                        cycles++;
                end
                if (hex2 !== SEG_FONT[MS_IDLE] || hex3 !== SEG_FONT[CS_POLL]) begin
                        $display("timeout: display never showed idle and poll states");
                        hung = 1'b1;
                end
        endtask

        // ==============================
        // test sequence
        // ==============================
        initial begin
                int i;
                int n;
                int errs_before;
                logic [7:0] a;
                logic [7:0] b;
                logic [7:0] p;
                logic [WORD_W-1:0] rd;

                host_we      = 1'b0;
                host_addr    = '0;
                host_wdata   = '0;
                errors       = 0;
                tests_run    = 0;
                tests_failed = 0;
                hung         = 1'b0;

                for (i = 0; i < 128; i++)
                        vec[7'(i)] = 8'hff;     // end marker, no operand is ff
                $readmemh("verification/mult_tests.txt", vec);
                n = 0;
                while (n < MAX_TESTS && vec[7'(3 * n)] != 8'hff)
                        n++;

                wait_reset_release();
                if (!hung) begin
                        errs_before = errors;
                        check_digit("hex0_o", hex0, 4'h0);
                        check_digit("hex1_o", hex1, 4'h0);
                        check_digit("hex2_o", hex2, 4'h0);
                        check_digit("hex3_o", hex3, 4'h0);
                        check_digit("hex4_o", hex4, 4'h0);
                        check_digit("hex5_o", hex5, 4'h0);
                        finish_test("digits after reset", errs_before);

                        errs_before = errors;
                        for (i = 2; i < 16; i++)
                                write_word(ADDR_W'(i), fill_word(ADDR_W'(i)));
                        for (i = 2; i < 16; i++) begin
                                read_word(ADDR_W'(i), rd);
                                if (rd !== fill_word(ADDR_W'(i)))
                                        report_mismatch($sformatf("host_rdata_o word %0d", i),
                                                        fill_word(ADDR_W'(i)), rd);
                        end
                        finish_test("ram words 2 to 15", errs_before);
                end

                for (i = 0; i < n && !hung; i++) begin
                        a = vec[7'(3 * i)];
                        b = vec[7'(3 * i + 1)];
                        p = vec[7'(3 * i + 2)];
                        errs_before = errors;
                        if (p !== a * b)
                                report_mismatch("product in test file", WORD_W'(a * b), WORD_W'(p));

                        write_word(RES_ADDR, '0);       // drop the last done flag
                        write_word(CMD_ADDR, cmd_word(a, b));
                        wait_done(rd);
                        if (!hung) begin
                                if (rd !== result_word(p))
                                        report_mismatch("host_rdata_o result", result_word(p), rd);
                                read_word(CMD_ADDR, rd);
                                if (rd !== {24'h0, b[3:0], a[3:0]})
                                        report_mismatch("host_rdata_o command",
                                                        {24'h0, b[3:0], a[3:0]}, rd);
                                check_digit("hex0_o", hex0, a[3:0]);
                                check_digit("hex1_o", hex1, b[3:0]);
                                check_digit("hex4_o", hex4, p[3:0]);
                                check_digit("hex5_o", hex5, p[7:4]);
                                wait_display_idle();
                        end
                        finish_test($sformatf("%0h times %0h", a, b), errs_before);
                end

                $display("tests %0d, failed %0d, mismatches %0d, assertion failures %0d",
                         tests_run, tests_failed, errors, UUT.u_props.fail_cnt);
                if (errors == 0 && !hung && UUT.u_props.fail_cnt == 0) begin
                        $display("SIMULATION PASSED");
                end else begin
                        $display("SIMULATION FAILED");
                end
                $finish;
        end

endmodule

// ==== verification/mult_tests.txt ====
// columns: operand a, operand b, expected product, all hex
// one test per line, a and b are 4-bit
0 0 00
1 1 01
3 5 0f
7 9 3f
a 6 3c
8 1 08
0 b 00
c d 9c
5 e 46
9 9 51
2 f 1e
f f e1

// ==== all.f ====
src/mult_pkg.sv
src/test_ram.sv
src/shift_add_multiplier.sv
src/mailbox_controller.sv
src/hex_display.sv
src/mult_soc_top.sv
verification/clk_gen.sv
verification/mult_props.sv
verification/tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module tb_top -f all.f -o sim_tb \
        || { echo "verilator build failed"; exit 1; }

./obj_dir/sim_tb 2>&1 | tee sim.log

grep -qx "SIMULATION PASSED" sim.log && echo "run ok" || { echo "run not ok"; exit 1; }
